// File: sources.f
+incdir+include
hdl/prince_pkg.sv
hdl/prince_round_ctrl.sv
hdl/prince_key_sched.sv
hdl/prince_round_unit.sv
hdl/prince_lane_datapath.sv
hdl/prince_core.sv
dv/prince_core_tb.sv

// File: include/prince_lane_model.svh
`ifndef PRINCE_LANE_MODEL_SVH
`define PRINCE_LANE_MODEL_SVH

// Reference result of one full lane run
function automatic prince_pkg::lane_t prince_lane_ref(
    input logic                  encrypt,
    input prince_pkg::lane_sel_t idx,
    input prince_pkg::key_t      k0,
    input prince_pkg::key_t      k1,
    input prince_pkg::lane_t     pt
);
    prince_pkg::key_t  k1_eff;
    prince_pkg::key_t  k0_prime;
    prince_pkg::key_t  k0_in;
    prince_pkg::key_t  k0_out;
    prince_pkg::lane_t k1_lane;
    prince_pkg::lane_t x;
    prince_pkg::lane_t t;
    logic              m0_sel;

    k1_eff   = encrypt ? k1 : (k1 ^ prince_pkg::ALPHA);
    k0_prime = {k0[0], k0[63:1]} ^ {63'd0, k0[63]};
    k0_in    = encrypt ? k0 : k0_prime;
    k0_out   = encrypt ? k0_prime : k0;
    k1_lane  = k1_eff[16*idx +: 16];
    m0_sel   = (idx == 2'd0) || (idx == 2'd3);

    // Input whitening
    x = pt ^ k0_in[16*idx +: 16] ^ k1_lane ^ prince_pkg::RC_TABLE[0][16*idx +: 16];

    // Forward rounds with RC 1..5
    for (int r = 1; r <= 5; r++) begin
        t = prince_pkg::sub_lane(x);
        t = m0_sel ? prince_pkg::mix_m0(t) : prince_pkg::mix_m1(t);
        x = prince_pkg::shift_rows(t) ^ k1_lane ^ prince_pkg::RC_TABLE[r][16*idx +: 16];
    end

    // Middle round
    t = prince_pkg::sub_lane(x);
    t = m0_sel ? prince_pkg::mix_m0(t) : prince_pkg::mix_m1(t);
    x = prince_pkg::sub_lane_inv(t);

    // Backward rounds with RC 6..10
    for (int r = 6; r <= 10; r++) begin
        t = x ^ k1_lane ^ prince_pkg::RC_TABLE[r][16*idx +: 16];
        t = prince_pkg::shift_rows_inv(t);
        t = m0_sel ? prince_pkg::mix_m0(t) : prince_pkg::mix_m1(t);
        x = prince_pkg::sub_lane_inv(t);
    end

    // Output whitening
    return x ^ k0_out[16*idx +: 16] ^ k1_lane ^ prince_pkg::RC_TABLE[11][16*idx +: 16];
endfunction

`endif

// File: dv/prince_core_tb.sv
`timescale 1ns/10ps

module prince_core_tb;
    import prince_pkg::*;

    // Reference lane model
    `include "prince_lane_model.svh"

    // ------------------------------
    // Run limits
    // ------------------------------
    localparam int RUN_COUNT      = 60;
    localparam int TIMEOUT_CYCLES = RUN_COUNT * 16 + 200;
    // Done edge is 13 edges past the start edge, the 14th counting the start edge
    localparam int DONE_EDGES     = 13;

    logic      clk;
    logic      rst_n;
    logic      encrypt;
    logic      block_start;
    logic      block_done;
    lane_sel_t outer_idx;
    key_t      k0;
    key_t      k1;
    lane_t     plain_text;
    lane_t     cipher_text;

    integer    seed;
    int        cycles;
    string     test_name;

    prince_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .encrypt     (encrypt),
        .block_start (block_start),
        .block_done  (block_done),
        .outer_idx   (outer_idx),
        .k0          (k0),
        .k1          (k1),
        .plain_text  (plain_text),
        .cipher_text (cipher_text)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on total cycle count
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_with_fail();
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %0h actual %0h", name, exp, act);
            stop_with_fail();
        end
    endtask

    task automatic rand_key(output key_t k);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        k  = {hi, lo};
    endtask

    task automatic rand_lane(output lane_t v);
        logic [31:0] r;
        r = $random(seed);
        v = r[15:0];
    endtask

    // One lane run from a falling edge, optionally disturbed mid-run
    task automatic run_lane(input logic enc, input lane_sel_t idx, input key_t ka,
                            input key_t kb, input lane_t pt, input logic disturb,
                            output lane_t ct);
        int    edges;
        lane_t exp;
        lane_t noise;
        exp         = prince_lane_ref(enc, idx, ka, kb, pt);
        encrypt     = enc;
        outer_idx   = idx;
        k0          = ka;
        k1          = kb;
        plain_text  = pt;
        block_start = 1'b1;
        // Start edge passes here
        @(negedge clk);
        block_start = 1'b0;
        // New plain text before the INPUT edge consumes the captured value
        if (disturb) begin
            rand_lane(noise);
            plain_text = noise;
        end
        edges       = 0;
        do begin
            @(negedge clk);
            edges++;
            block_start = 1'b0;
            // Stray start while in FWD
            if (disturb && edges == 3) begin
                block_start = 1'b1;
            end
        end while (!block_done && edges < 3 * DONE_EDGES);
        assert (block_done) else begin
            $display("block_done never rose in test %s", test_name);
            stop_with_fail();
        end
        check_value({test_name, " done latency"}, DONE_EDGES, edges);
        ct = cipher_text;
        check_value({test_name, " cipher_text"}, exp, ct);
        // Pulse lasts one cycle
        @(negedge clk);
        check_value({test_name, " done width"}, 0, block_done);
    endtask

    // Idle cycles with moving plain text, result and done must hold
    task automatic hold_check(input int n);
        lane_t held;
        lane_t noise;
        held = cipher_text;
        repeat (n) begin
            @(negedge clk);
            rand_lane(noise);
            plain_text = noise;
            check_value({test_name, " hold cipher_text"}, held, cipher_text);
            check_value({test_name, " idle block_done"}, 0, block_done);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        key_t        ka;
        key_t        kb;
        lane_t       pt;
        lane_t       ct;
        lane_t       ct_dec;
        logic [31:0] r;
        seed        = 32'h6a77cc24;
        test_name   = "reset";
        rst_n       = 1'b0;
        encrypt     = 1'b1;
        block_start = 1'b0;
        outer_idx   = '0;
        k0          = '0;
        k1          = '0;
        plain_text  = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset block_done", 0, block_done);
        @(negedge clk);

        // Encrypt on random lanes
        test_name = "encrypt";
        for (int i = 0; i < 16; i++) begin
            rand_key(ka);
            rand_key(kb);
            rand_lane(pt);
            r = $random(seed);
            run_lane(1'b1, r[1:0], ka, kb, pt, 1'b0, ct);
        end

        // Decrypt, every lane so both m0 and m1 run
        test_name = "decrypt";
        for (int i = 0; i < 16; i++) begin
            rand_key(ka);
            rand_key(kb);
            rand_lane(pt);
            run_lane(1'b0, i[1:0], ka, kb, pt, 1'b0, ct);
        end

        // Encrypt then decrypt the result with the same keys and lane
        test_name = "round trip";
        for (int i = 0; i < 10; i++) begin
            rand_key(ka);
            rand_key(kb);
            rand_lane(pt);
            run_lane(1'b1, i[1:0], ka, kb, pt, 1'b0, ct);
            run_lane(1'b0, i[1:0], ka, kb, ct, 1'b0, ct_dec);
            // Alpha reflection brings back the plain text
            check_value({test_name, " recovered plain_text"}, pt, ct_dec);
        end

        // Mid-run plain text change and stray start
        test_name = "input capture";
        for (int i = 0; i < 2; i++) begin
            rand_key(ka);
            rand_key(kb);
            rand_lane(pt);
            run_lane(i[0], 2'd3 - i[1:0], ka, kb, pt, 1'b1, ct);
            hold_check(16);
        end

        // Plain idle hold after an ordinary run
        test_name = "hold";
        rand_key(ka);
        rand_key(kb);
        rand_lane(pt);
        run_lane(1'b1, 2'd1, ka, kb, pt, 1'b0, ct);
        hold_check(8);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hdl/prince_core.sv
`timescale 1ns/10ps

module prince_core (
    input  logic                clk,
    input  logic                rst_n,

    // Control
    input  logic                encrypt,
    input  logic                block_start,
    output logic                block_done,

    // Data
    input  prince_pkg::lane_sel_t outer_idx,
    input  prince_pkg::key_t    k0,
    input  prince_pkg::key_t    k1,
    input  prince_pkg::lane_t   plain_text,
    output prince_pkg::lane_t   cipher_text
);
    import prince_pkg::*;

    // Sequencer outputs
    round_state_e state;
    rc_idx_t      rc_idx;

    // Lane keys for whitening and rounds
    lane_t        pre_key;
    lane_t        post_key;
    lane_t        round_key;

    // ------------------------------
    // Run sequencer
    // ------------------------------
    prince_round_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_start (block_start),
        .state       (state),
        .rc_idx      (rc_idx),
        .block_done  (block_done)
    );

    // ------------------------------
    // Key derivation, combinational
    // ------------------------------
    prince_key_sched u_key (
        .encrypt   (encrypt),
        .outer_idx (outer_idx),
        .k0        (k0),
        .k1        (k1),
        .rc_idx    (rc_idx),
        .pre_key   (pre_key),
        .post_key  (post_key),
        .round_key (round_key)
    );

    // Lane state and round logic
    prince_lane_datapath u_data (
        .clk         (clk),
        .state       (state),
        .outer_idx   (outer_idx),
        .plain_text  (plain_text),
        .pre_key     (pre_key),
        .post_key    (post_key),
        .round_key   (round_key),
        .cipher_text (cipher_text)
    );

endmodule

// File: hdl/prince_lane_datapath.sv
`timescale 1ns/10ps

module prince_lane_datapath (
    input  logic                     clk,
    input  prince_pkg::round_state_e state,
    input  prince_pkg::lane_sel_t    outer_idx,
    input  prince_pkg::lane_t        plain_text,
    input  prince_pkg::lane_t        pre_key,
    input  prince_pkg::lane_t        post_key,
    input  prince_pkg::lane_t        round_key,
    output prince_pkg::lane_t        cipher_text
);
    import prince_pkg::*;

    // Plain text captured while idle
    lane_t plain_q;
    // Lane state, also the visible result
    lane_t lane_q;
    lane_t round_out;

    // Shared by all eleven rounds
    prince_round_unit u_round (
        .state     (state),
        .outer_idx (outer_idx),
        .lane_in   (lane_q),
        .round_key (round_key),
        .lane_out  (round_out)
    );

    // ------------------------------
    // One update per state
    // ------------------------------
    always_ff @(posedge clk) begin
        case (state)
            IDLE:  plain_q <= plain_text;
            // Input whitening
            INPUT: lane_q  <= plain_q ^ pre_key;
            FWD, MID, BWD: begin
                lane_q <= round_out;
            end
            // Output whitening
            DONE:  lane_q  <= lane_q ^ post_key;
            default: begin
                lane_q <= lane_q;
            end
        endcase
    end

    // Held through IDLE until next INPUT
    assign cipher_text = lane_q;

endmodule

// File: hdl/prince_round_unit.sv
`timescale 1ns/10ps

module prince_round_unit (
    input  prince_pkg::round_state_e state,
    input  prince_pkg::lane_sel_t    outer_idx,
    input  prince_pkg::lane_t        lane_in,
    input  prince_pkg::lane_t        round_key,
    output prince_pkg::lane_t        lane_out
);
    import prince_pkg::*;

    // Stage outputs through the round
    lane_t keyed;
    lane_t first_layer;
    lane_t mixed;
    lane_t last_layer;

    // Reconfiguration controls
    logic  is_fwd;
    logic  is_bwd;
    logic  use_m0;

    assign is_fwd = (state == FWD);
    assign is_bwd = (state == BWD);

    // Outer lanes take m0, inner lanes m1
    assign use_m0 = (outer_idx == 2'd0) || (outer_idx == 2'd3);

    // ------------------------------
    // Round datapath
    // ------------------------------
    // FWD   S, mix, shift rows, key
    // MID   S, mix, S inverse
    // BWD   key, shift rows inverse, mix, S inverse
    always_comb begin
        // Key enters first only on the backward side
        keyed       = is_bwd ? (lane_in ^ round_key) : lane_in;

        first_layer = is_bwd ? shift_rows_inv(keyed) : sub_lane(keyed);

        // Single mixing layer for every round kind
        mixed       = use_m0 ? mix_m0(first_layer) : mix_m1(first_layer);

        last_layer  = is_fwd ? shift_rows(mixed) : sub_lane_inv(mixed);

        // Key closes the forward round
        lane_out    = is_fwd ? (last_layer ^ round_key) : last_layer;
    end

endmodule

// File: hdl/prince_key_sched.sv
`timescale 1ns/10ps

module prince_key_sched (
    input  logic                  encrypt,
    input  prince_pkg::lane_sel_t outer_idx,
    input  prince_pkg::key_t      k0,
    input  prince_pkg::key_t      k1,
    input  prince_pkg::rc_idx_t   rc_idx,
    output prince_pkg::lane_t     pre_key,
    output prince_pkg::lane_t     post_key,
    output prince_pkg::lane_t     round_key
);
    import prince_pkg::*;

    // Full-width derived keys
    key_t       k1_eff;
    key_t       k0_prime;
    key_t       k0_in;
    key_t       k0_out;
    key_t       rc_word;

    // Bit offset of the selected lane
    logic [5:0] lane_base;
    lane_t      k1_lane;

    // ------------------------------
    // Key derivation
    // ------------------------------
    // Decryption folds alpha into k1
    assign k1_eff   = encrypt ? k1 : (k1 ^ ALPHA);

    // k0 prime, rotate right by one and fold old bit 63 into bit 0
    assign k0_prime = {k0[0], k0[63:1]} ^ {63'd0, k0[63]};

    // Whitening roles of k0 swap when decrypting
    assign k0_in    = encrypt ? k0 : k0_prime;
    assign k0_out   = encrypt ? k0_prime : k0;

    assign rc_word  = RC_TABLE[rc_idx];

    // ------------------------------
    // Lane selection
    // ------------------------------
    assign lane_base = {outer_idx, 4'b0000};
    assign k1_lane   = k1_eff[lane_base +: 16];

    // Input whitening, k0 role plus k1 plus RC 0
    assign pre_key   = k0_in[lane_base +: 16] ^ k1_lane ^ RC_TABLE[0][lane_base +: 16];

    // Output whitening, RC 11
    assign post_key  = k0_out[lane_base +: 16] ^ k1_lane ^ RC_TABLE[11][lane_base +: 16];

    // Per-round key
    assign round_key = k1_lane ^ rc_word[lane_base +: 16];

endmodule

// File: hdl/prince_round_ctrl.sv
`timescale 1ns/10ps

module prince_round_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     block_start,
    output prince_pkg::round_state_e state,
    output prince_pkg::rc_idx_t      rc_idx,
    output logic                     block_done
);
    import prince_pkg::*;

    // Five rounds in each of FWD and BWD
    localparam logic [2:0] LAST_ROUND = 3'd4;

    // Round position inside FWD or BWD
    logic [2:0] round_cnt;

    // ------------------------------
    // State walk
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            round_cnt  <= '0;
            block_done <= 1'b0;
        end else begin
            // Pulse in the cycle after DONE
            block_done <= (state == DONE);
            case (state)
                // Start only honoured here
                IDLE: begin
                    if (block_start) begin
                        state <= INPUT;
                    end
                end
                INPUT: begin
                    state     <= FWD;
                    round_cnt <= '0;
                end
                FWD: begin
                    if (round_cnt == LAST_ROUND) begin
                        state     <= MID;
                        round_cnt <= '0;
                    end else begin
                        round_cnt <= round_cnt + 3'd1;
                    end
                end
                // Counter already cleared on FWD exit
                MID: state <= BWD;
                BWD: begin
                    if (round_cnt == LAST_ROUND) begin
                        state     <= DONE;
                        round_cnt <= '0;
                    end else begin
                        round_cnt <= round_cnt + 3'd1;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------
    // Round-constant index
    // ------------------------------
    // FWD uses RC 1..5, MID RC 11, BWD RC 6..10
    always_comb begin
        case (state)
            FWD:     rc_idx = {1'b0, round_cnt} + 4'd1;
            MID:     rc_idx = 4'd11;
            BWD:     rc_idx = {1'b0, round_cnt} + 4'd6;
            default: rc_idx = '0;
        endcase
    end

endmodule

// File: hdl/prince_pkg.sv
package prince_pkg;

    // ------------------------------
    // Widths and types
    // ------------------------------
    // One 16-bit lane of state or key
    typedef logic [15:0] lane_t;
    // Full 64-bit key word
    typedef logic [63:0] key_t;
    // Lane index, lane n covers bits 16n..16n+15
    typedef logic [1:0]  lane_sel_t;
    // Round-constant index, 0 to 11
    typedef logic [3:0]  rc_idx_t;

    // Lane run sequencer states
    typedef enum logic [3:0] {
        IDLE,
        INPUT,
        FWD,
        MID,
        BWD,
        DONE
    } round_state_e;

    // ------------------------------
    // Constants
    // ------------------------------
    // Round constants, RC 0 is zero and RC 11 equals alpha
    localparam key_t RC_TABLE [12] = '{
        64'h0000000000000000, 64'h13198a2e03707344, 64'ha4093822299f31d0,
        64'h082efa98ec4e6c89, 64'h452821e638d01377, 64'hbe5466cf34e90c6c,
        64'h7ef84f78fd955cb1, 64'h85840851f1ac43aa, 64'hc882d32f25323c54,
        64'h64a51195e0e3610d, 64'hd3b5a399ca0c2399, 64'hc0ac29b7c97c50dd
    };

    // XORed into k1 for decryption
    localparam key_t ALPHA = 64'hc0ac29b7c97c50dd;

    // 4-bit S-box and its inverse
    localparam logic [3:0] SBOX [16] = '{
        4'hb, 4'hf, 4'h3, 4'h2, 4'ha, 4'hc, 4'h9, 4'h1,
        4'h6, 4'h7, 4'h8, 4'h0, 4'he, 4'h5, 4'hd, 4'h4
    };
    localparam logic [3:0] SBOX_INV [16] = '{
        4'hb, 4'h7, 4'h3, 4'h2, 4'hf, 4'hd, 4'h8, 4'h9,
        4'ha, 4'h6, 4'h4, 4'h0, 4'h5, 4'he, 4'hc, 4'h1
    };

    // Shift rows, output bit i takes input bit SR_MAP[i]
    localparam logic [3:0] SR_MAP [16] = '{
        4'd0, 4'd5, 4'd10, 4'd15, 4'd4, 4'd9, 4'd14, 4'd3,
        4'd8, 4'd13, 4'd2, 4'd7, 4'd12, 4'd1, 4'd6, 4'd11
    };

    // Mixing layers, each output bit is the parity of the masked input
    localparam lane_t M0_MASK [16] = '{
        16'h0111, 16'h2220, 16'h4404, 16'h8088, 16'h1011, 16'h0222, 16'h4440, 16'h8808,
        16'h1101, 16'h2022, 16'h0444, 16'h8880, 16'h1110, 16'h2202, 16'h4044, 16'h0888
    };
    localparam lane_t M1_MASK [16] = '{
        16'h1110, 16'h2202, 16'h4044, 16'h0888, 16'h0111, 16'h2220, 16'h4404, 16'h8088,
        16'h1011, 16'h0222, 16'h4440, 16'h8808, 16'h1101, 16'h2022, 16'h0444, 16'h8880
    };

    // ------------------------------
    // Lane functions
    // ------------------------------
    function automatic logic [3:0] sbox_4(input logic [3:0] x);
        return SBOX[x];
    endfunction

    function automatic logic [3:0] sbox_inv_4(input logic [3:0] x);
        return SBOX_INV[x];
    endfunction

    // S-layer over the four nibbles of a lane
    function automatic lane_t sub_lane(input lane_t x);
        lane_t y;
        for (int i = 0; i < 4; i++) begin
            y[4*i +: 4] = sbox_4(x[4*i +: 4]);
        end
        return y;
    endfunction

    function automatic lane_t sub_lane_inv(input lane_t x);
        lane_t y;
        for (int i = 0; i < 4; i++) begin
            y[4*i +: 4] = sbox_inv_4(x[4*i +: 4]);
        end
        return y;
    endfunction

    function automatic lane_t shift_rows(input lane_t x);
        lane_t y;
        for (int i = 0; i < 16; i++) begin
            y[i] = x[SR_MAP[i]];
        end
        return y;
    endfunction

    // Scatter back through the same map
    function automatic lane_t shift_rows_inv(input lane_t x);
        lane_t y;
        for (int i = 0; i < 16; i++) begin
            y[SR_MAP[i]] = x[i];
        end
        return y;
    endfunction

    // m0 used by lanes 0 and 3
    function automatic lane_t mix_m0(input lane_t x);
        lane_t y;
        for (int i = 0; i < 16; i++) begin
            y[i] = ^(x & M0_MASK[i]);
        end
        return y;
    endfunction

    // m1 used by lanes 1 and 2
    function automatic lane_t mix_m1(input lane_t x);
        lane_t y;
        for (int i = 0; i < 16; i++) begin
            y[i] = ^(x & M1_MASK[i]);
        end
        return y;
    endfunction

endpackage
